// File: hdl/mma_consts.svh
/*
 * Sizes, protocol byte values and the receive timeout of the matrix-multiply
 * accelerator. Included by the package and by every RTL file that needs them.
 */
`ifndef MMA_CONSTS_SVH
`define MMA_CONSTS_SVH

// Matrix geometry
`define MMA_MAX_DIM 8       // Largest side of a matrix
`define MMA_DEPTH 64        // Elements per store
`define MMA_ADDR_W 6        // Store address width
`define MMA_DIM_W 4         // Dimension register width

// Idle cycles allowed between bytes of a word
`define MMA_RX_TIMEOUT 1000

// Command bytes, host to accelerator
`define MMA_CMD_RX_A 8'h01
`define MMA_CMD_RX_B 8'h02
`define MMA_CMD_MULTIPLY 8'h03
`define MMA_CMD_TX_R 8'h04

// Reply bytes, accelerator to host
`define MMA_REPLY_DONE 8'h05
`define MMA_REPLY_ACK 8'h06
`define MMA_REPLY_ERR 8'hAA

`endif

// File: hdl/mma_controller.sv
/*
 * Command controller. Runs matrix loads, checks dimensions, streams the
 * multiply through the A/B stores into R and reads R back for transmit.
 */
`timescale 1ns/1ps
`include "mma_consts.svh"

module mma_controller import mma_pkg::*; (
    input  logic       CLK100MHZ,
    input  logic       reset_i,
    input  cmd_e       cmd_i,
    input  logic       cmd_valid_i,
    input  word_t      word_i,
    input  logic       word_valid_i,
    input  logic       rx_timeout_i,
    input  logic       tx_idle_i,
    input  elem_t      a_rdata_i,
    input  elem_t      b_rdata_i,
    input  acc_t       r_rdata_i,
    output logic       expect_word_o,
    output logic       a_we_o,
    output logic       b_we_o,
    output logic       r_we_o,
    output addr_t      a_addr_o,
    output addr_t      b_addr_o,
    output addr_t      r_addr_o,
    output elem_t      a_wdata_o,
    output elem_t      b_wdata_o,
    output acc_t       r_wdata_o,
    output logic [7:0] status_o,
    output logic       status_valid_o,
    output word_t      tx_word_o,
    output logic       tx_word_valid_o
);

    typedef enum logic [3:0] {
        S_IDLE, S_LD_DIM0, S_LD_DIM1, S_LD_DATA, S_MUL_RUN,
        S_MUL_DRAIN, S_TX_DIM0, S_TX_DIM1, S_TX_DATA, S_REPLY
    } state_e;

    state_e state_q;
    dim_t   a_m;                                    // A rows
    dim_t   a_n;                                    // A columns
    dim_t   b_m;                                    // B rows
    dim_t   b_n;                                    // B columns
    dim_t   r_m;                                    // R rows, set by a good multiply
    dim_t   r_n;                                    // R columns
    dim_t   i_q;                                    // Row of A and R
    dim_t   j_q;                                    // Column of B and R
    dim_t   k_q;                                    // Inner index
    logic   ld_b_q;                                 // Load targets B
    addr_t  idx_q;                                  // Load, R write and R read index
    addr_t  ld_last;
    addr_t  r_last;
    addr_t  mul_a_addr;
    addr_t  mul_b_addr;
    logic   mac_v_q;                                // A/B read data valid
    logic   mac_first_q;                            // Product starts a new element
    logic   mac_last_q;                             // Product closes an element
    logic   wr_q;                                   // R write of acc_q
    acc_t   acc_q;
    logic   tx_ready;

    function automatic logic dim_ok(word_t w);
        return (w != 0) && (w <= `MMA_MAX_DIM);
    endfunction

    // Idle and no request still on its way in
    assign tx_ready = tx_idle_i && !status_valid_o && !tx_word_valid_o;
    assign expect_word_o = (state_q == S_LD_DIM0) || (state_q == S_LD_DIM1)
                        || (state_q == S_LD_DATA);

    assign ld_last    = ld_b_q ? b_m * b_n - 1 : a_m * a_n - 1;
    assign r_last     = r_m * r_n - 1;
    assign mul_a_addr = i_q * a_n + k_q;            // A[i][k]
    assign mul_b_addr = k_q * b_n + j_q;            // B[k][j]

    assign a_addr_o  = (state_q == S_MUL_RUN) ? mul_a_addr : idx_q;
    assign b_addr_o  = (state_q == S_MUL_RUN) ? mul_b_addr : idx_q;
    assign r_addr_o  = idx_q;
    assign a_we_o    = (state_q == S_LD_DATA) && word_valid_i && !ld_b_q;
    assign b_we_o    = (state_q == S_LD_DATA) && word_valid_i && ld_b_q;
    assign r_we_o    = wr_q;
    assign a_wdata_o = word_i[15:0];                // Signed low half
    assign b_wdata_o = word_i[15:0];
    assign r_wdata_o = acc_q;

    // MAC on the read data of the previous cycle's addresses
    always_ff @(posedge CLK100MHZ) begin
        if (mac_v_q) begin
            acc_q <= (mac_first_q ? acc_t'(0) : acc_q) + a_rdata_i * b_rdata_i;
        end
    end

    always_ff @(posedge CLK100MHZ) begin
        if (reset_i) begin
            state_q         <= S_IDLE;
            a_m             <= '0;
            a_n             <= '0;
            b_m             <= '0;
            b_n             <= '0;
            r_m             <= '0;
            r_n             <= '0;
            i_q             <= '0;
            j_q             <= '0;
            k_q             <= '0;
            ld_b_q          <= 1'b0;
            idx_q           <= '0;
            mac_v_q         <= 1'b0;
            wr_q            <= 1'b0;
            status_valid_o  <= 1'b0;
            tx_word_valid_o <= 1'b0;
        end else begin
            status_valid_o  <= 1'b0;
            tx_word_valid_o <= 1'b0;
            mac_v_q         <= (state_q == S_MUL_RUN);
            wr_q            <= mac_v_q && mac_last_q;
            if (wr_q) begin
                idx_q <= idx_q + 1'b1;              // Next R element
            end
            case (state_q)
                S_IDLE: if (cmd_valid_i) begin
                    case (cmd_i)
                        CMD_RX_A, CMD_RX_B: begin
                            ld_b_q  <= (cmd_i == CMD_RX_B);
                            state_q <= S_LD_DIM0;
                        end
                        CMD_MULTIPLY: begin
                            if (a_n != b_m || !dim_ok(a_m) || !dim_ok(a_n) || !dim_ok(b_n)) begin
                                status_o <= `MMA_REPLY_ERR;   // Incompatible or not loaded
                                state_q  <= S_REPLY;
                            end else begin
                                i_q     <= '0;
                                j_q     <= '0;
                                k_q     <= '0;
                                idx_q   <= '0;
                                state_q <= S_MUL_RUN;
                            end
                        end
                        CMD_TX_R: state_q <= S_TX_DIM0;
                        default: state_q <= S_IDLE;
                    endcase
                end
                S_LD_DIM0, S_LD_DIM1: begin
                    if (rx_timeout_i || (word_valid_i && !dim_ok(word_i))) begin
                        status_o <= `MMA_REPLY_ERR;
                        state_q  <= S_REPLY;
                    end else if (word_valid_i && state_q == S_LD_DIM0) begin
                        if (ld_b_q) b_m <= word_i[`MMA_DIM_W-1:0];
                        else        a_m <= word_i[`MMA_DIM_W-1:0];
                        state_q <= S_LD_DIM1;
                    end else if (word_valid_i) begin
                        if (ld_b_q) b_n <= word_i[`MMA_DIM_W-1:0];
                        else        a_n <= word_i[`MMA_DIM_W-1:0];
                        idx_q   <= '0;
                        state_q <= S_LD_DATA;
                    end
                end
                S_LD_DATA: begin
                    if (rx_timeout_i) begin
                        status_o <= `MMA_REPLY_ERR;
                        state_q  <= S_REPLY;
                    end else if (word_valid_i && idx_q == ld_last) begin
                        status_o <= `MMA_REPLY_ACK;   // Last element written now
                        state_q  <= S_REPLY;
                    end else if (word_valid_i) begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
                S_MUL_RUN: begin                    // One A/B address pair per cycle
                    mac_first_q <= (k_q == '0);
                    mac_last_q  <= (k_q == a_n - 1'b1);
                    if (k_q != a_n - 1'b1) begin
                        k_q <= k_q + 1'b1;
                    end else begin
                        k_q <= '0;
                        if (j_q != b_n - 1'b1) begin
                            j_q <= j_q + 1'b1;
                        end else begin
                            j_q <= '0;
                            i_q <= i_q + 1'b1;
                            if (i_q == a_m - 1'b1) state_q <= S_MUL_DRAIN;
                        end
                    end
                end
                S_MUL_DRAIN: if (!mac_v_q && !wr_q) begin   // Last R write done
                    r_m      <= a_m;
                    r_n      <= b_n;
                    status_o <= `MMA_REPLY_DONE;
                    state_q  <= S_REPLY;
                end
                S_TX_DIM0: if (tx_ready) begin
                    tx_word_o       <= r_m;
                    tx_word_valid_o <= 1'b1;
                    state_q         <= S_TX_DIM1;
                end
                S_TX_DIM1: if (tx_ready) begin
                    tx_word_o       <= r_n;
                    tx_word_valid_o <= 1'b1;
                    idx_q           <= '0;          // R[0] read while dims go out
                    state_q         <= dim_ok(r_m) ? S_TX_DATA : S_IDLE;
                end
                S_TX_DATA: if (tx_ready) begin
                    tx_word_o       <= r_rdata_i;
                    tx_word_valid_o <= 1'b1;
                    idx_q           <= idx_q + 1'b1;
                    if (idx_q == r_last) state_q <= S_IDLE;
                end
                S_REPLY: if (tx_ready) begin
                    status_valid_o <= 1'b1;
                    state_q        <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/mma_matrix_ram.sv
/*
 * Single-port matrix store with synchronous write and registered read.
 * One instance per matrix, payload type chosen by the parameter.
 */
`timescale 1ns/1ps
`include "mma_consts.svh"

module mma_matrix_ram import mma_pkg::*; #(
    parameter type payload_t = elem_t
) (
    input  logic     CLK100MHZ,
    input  logic     we_i,
    input  addr_t    addr_i,
    input  payload_t wdata_i,
    output payload_t rdata_o
);

    payload_t mem [`MMA_DEPTH];                     // Row-major elements

    always_ff @(posedge CLK100MHZ) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];                     // Old data on a write cycle
    end

endmodule

// File: hdl/mma_pkg.sv
/*
 * Shared types of the accelerator: operands, results, protocol words,
 * dimensions, store addresses and decoded commands.
 */
`include "mma_consts.svh"

package mma_pkg;

    typedef logic signed [15:0] elem_t;             // Low half of a received word
    typedef logic signed [31:0] acc_t;              // Wrapped sum of products
    typedef logic [31:0] word_t;                    // Big-endian protocol word
    typedef logic [`MMA_DIM_W-1:0] dim_t;           // One matrix side
    typedef logic [`MMA_ADDR_W-1:0] addr_t;         // Row-major element index

    // Decoded command, none when idle
    typedef enum logic [2:0] {
        CMD_NONE,
        CMD_RX_A,
        CMD_RX_B,
        CMD_MULTIPLY,
        CMD_TX_R
    } cmd_e;

endpackage

// File: hdl/mma_top.sv
/*
 * Accelerator top level. Byte receive, controller with the A, B and R
 * stores, and byte transmit, joined by loose wires.
 */
`timescale 1ns/1ps

module mma_top import mma_pkg::*; (
    input  logic       CLK100MHZ,
    input  logic       reset_i,
    input  logic [7:0] rx_data_i,
    input  logic       rx_valid_i,
    input  logic       tx_busy_i,
    output logic [7:0] tx_data_o,
    output logic       tx_valid_o
);

    cmd_e       cmd;
    logic       cmd_valid;
    word_t      word;
    logic       word_valid;
    logic       rx_timeout;
    logic       expect_word;
    logic       tx_idle;
    logic [7:0] status;
    logic       status_valid;
    word_t      tx_word;
    logic       tx_word_valid;
    logic       a_we;
    logic       b_we;
    logic       r_we;
    addr_t      a_addr;
    addr_t      b_addr;
    addr_t      r_addr;
    elem_t      a_wdata;
    elem_t      b_wdata;
    acc_t       r_wdata;
    elem_t      a_rdata;
    elem_t      b_rdata;
    acc_t       r_rdata;

    mma_word_rx u_word_rx (
        .CLK100MHZ, .reset_i, .rx_data_i, .rx_valid_i,
        .expect_word_i(expect_word), .cmd_o(cmd), .cmd_valid_o(cmd_valid),
        .word_o(word), .word_valid_o(word_valid), .rx_timeout_o(rx_timeout)
    );

    mma_controller u_controller (
        .CLK100MHZ, .reset_i,
        .cmd_i(cmd), .cmd_valid_i(cmd_valid), .word_i(word), .word_valid_i(word_valid),
        .rx_timeout_i(rx_timeout), .tx_idle_i(tx_idle),
        .a_rdata_i(a_rdata), .b_rdata_i(b_rdata), .r_rdata_i(r_rdata),
        .expect_word_o(expect_word), .a_we_o(a_we), .b_we_o(b_we), .r_we_o(r_we),
        .a_addr_o(a_addr), .b_addr_o(b_addr), .r_addr_o(r_addr),
        .a_wdata_o(a_wdata), .b_wdata_o(b_wdata), .r_wdata_o(r_wdata),
        .status_o(status), .status_valid_o(status_valid),
        .tx_word_o(tx_word), .tx_word_valid_o(tx_word_valid)
    );

    mma_matrix_ram #(.payload_t(elem_t)) u_ram_a (
        .CLK100MHZ, .we_i(a_we), .addr_i(a_addr), .wdata_i(a_wdata), .rdata_o(a_rdata)
    );

    mma_matrix_ram #(.payload_t(elem_t)) u_ram_b (
        .CLK100MHZ, .we_i(b_we), .addr_i(b_addr), .wdata_i(b_wdata), .rdata_o(b_rdata)
    );

    mma_matrix_ram #(.payload_t(acc_t)) u_ram_r (
        .CLK100MHZ, .we_i(r_we), .addr_i(r_addr), .wdata_i(r_wdata), .rdata_o(r_rdata)
    );

    mma_word_tx u_word_tx (
        .CLK100MHZ, .reset_i,
        .status_i(status), .status_valid_i(status_valid),
        .word_i(tx_word), .word_valid_i(tx_word_valid),
        .tx_busy_i, .tx_data_o, .tx_valid_o, .tx_idle_o(tx_idle)
    );

endmodule

// File: hdl/mma_word_rx.sv
/*
 * Receive stage. Bytes are decoded as commands while no word is expected,
 * otherwise shifted into big-endian words. A stalled word raises a timeout.
 */
`timescale 1ns/1ps
`include "mma_consts.svh"

module mma_word_rx import mma_pkg::*; (
    input  logic       CLK100MHZ,
    input  logic       reset_i,
    input  logic [7:0] rx_data_i,
    input  logic       rx_valid_i,
    input  logic       expect_word_i,
    output cmd_e       cmd_o,
    output logic       cmd_valid_o,
    output word_t      word_o,
    output logic       word_valid_o,
    output logic       rx_timeout_o
);

    localparam int IDLE_W = $clog2(`MMA_RX_TIMEOUT);

    word_t             shift_q;                     // Bytes in, MSB first
    logic [1:0]        byte_cnt_q;                  // Bytes of current word
    logic [IDLE_W-1:0] idle_q;                      // Cycles since last byte

    assign word_o = shift_q;                        // Complete when word_valid_o pulses

    always_ff @(posedge CLK100MHZ) begin
        if (reset_i) begin
            cmd_o        <= CMD_NONE;
            cmd_valid_o  <= 1'b0;
            word_valid_o <= 1'b0;
            rx_timeout_o <= 1'b0;
            byte_cnt_q   <= '0;
            idle_q       <= '0;
        end else begin
            cmd_valid_o  <= 1'b0;
            word_valid_o <= 1'b0;
            rx_timeout_o <= 1'b0;
            if (!expect_word_i) begin
                byte_cnt_q <= '0;                   // No partial word across commands
                idle_q     <= '0;
                if (rx_valid_i) begin
                    cmd_valid_o <= 1'b1;
                    case (rx_data_i)
                        `MMA_CMD_RX_A:     cmd_o <= CMD_RX_A;
                        `MMA_CMD_RX_B:     cmd_o <= CMD_RX_B;
                        `MMA_CMD_MULTIPLY: cmd_o <= CMD_MULTIPLY;
                        `MMA_CMD_TX_R:     cmd_o <= CMD_TX_R;
                        default:           cmd_valid_o <= 1'b0;   // Unknown byte dropped
                    endcase
                end
            end else if (rx_valid_i) begin
                shift_q    <= {shift_q[23:0], rx_data_i};
                byte_cnt_q <= byte_cnt_q + 1'b1;    // Wraps to 0 after 4th byte
                idle_q     <= '0;
                if (byte_cnt_q == 2'd3) begin
                    word_valid_o <= 1'b1;
                end
            end else if (idle_q == IDLE_W'(`MMA_RX_TIMEOUT - 1)) begin
                rx_timeout_o <= 1'b1;               // Single pulse, then count again
                byte_cnt_q   <= '0;
                idle_q       <= '0;
            end else begin
                idle_q <= idle_q + 1'b1;
            end
        end
    end

endmodule

// File: hdl/mma_word_tx.sv
/*
 * Transmit stage. Takes a status byte or a word from the controller and
 * sends it MSB first, one strobe per free cycle of the busy level.
 */
`timescale 1ns/1ps

module mma_word_tx import mma_pkg::*; (
    input  logic       CLK100MHZ,
    input  logic       reset_i,
    input  logic [7:0] status_i,
    input  logic       status_valid_i,
    input  word_t      word_i,
    input  logic       word_valid_i,
    input  logic       tx_busy_i,
    output logic [7:0] tx_data_o,
    output logic       tx_valid_o,
    output logic       tx_idle_o
);

    word_t      shift_q;                            // Next byte on top
    logic [2:0] left_q;                             // Bytes still to send
    logic       sent_q;                             // Strobe last cycle

    assign tx_idle_o  = (left_q == 3'd0);
    // Gap after each strobe lets the sink raise busy in time
    assign tx_valid_o = !tx_idle_o && !tx_busy_i && !sent_q;
    assign tx_data_o  = shift_q[31:24];

    always_ff @(posedge CLK100MHZ) begin
        if (reset_i) begin
            left_q <= '0;
            sent_q <= 1'b0;
        end else begin
            sent_q <= tx_valid_o;
            if (tx_idle_o) begin
                if (word_valid_i) begin
                    shift_q <= word_i;
                    left_q  <= 3'd4;
                end else if (status_valid_i) begin
                    shift_q <= {status_i, 24'h0};   // Single byte on top
                    left_q  <= 3'd1;
                end
            end else if (tx_valid_o) begin
                shift_q <= {shift_q[23:0], 8'h00};
                left_q  <= left_q - 1'b1;
            end
        end
    end

endmodule

// File: mma.f
+incdir+hdl
hdl/mma_pkg.sv
hdl/mma_word_rx.sv
hdl/mma_matrix_ram.sv
hdl/mma_controller.sv
hdl/mma_word_tx.sv
hdl/mma_top.sv
tb/mma_properties.sv
tb/mma_tb.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f mma.f --top-module mma_tb -o mma_sim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/mma_sim > sim.log 2>&1 \
    || echo "Simulator returned a non-zero status" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "All checks passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// File: tb/mma_properties.sv
/*
 * Transmit strobe rules of the accelerator top level.
 * Attached to every mma_top instance by the bind below.
 */
`timescale 1ns/1ps

module mma_properties (
    input logic CLK100MHZ,
    input logic reset_i,
    input logic tx_busy_i,
    input logic tx_valid_o
);

    // Strobe only while the sink is free
    no_strobe_when_busy: assert property (
        @(posedge CLK100MHZ) disable iff (reset_i) !(tx_valid_o && tx_busy_i)
    ) else $error("tx_valid_o high while tx_busy_i is high");

    // One-cycle strobes, gap before the next byte
    single_cycle_strobe: assert property (
        @(posedge CLK100MHZ) disable iff (reset_i) tx_valid_o |=> !tx_valid_o
    ) else $error("tx_valid_o high for two cycles in a row");

    quiet_after_reset: assert property (
        @(posedge CLK100MHZ) reset_i |=> !tx_valid_o
    ) else $error("tx_valid_o high in the cycle after reset");

endmodule

bind mma_top mma_properties u_properties (
    .CLK100MHZ(CLK100MHZ),
    .reset_i(reset_i),
    .tx_busy_i(tx_busy_i),
    .tx_valid_o(tx_valid_o)
);

// File: tb/mma_tb.sv
/*
 * Testbench for the matrix-multiply accelerator. Loads matrices over the byte
 * stream, multiplies, reads R back under random busy back-pressure and
 * compares every reply byte in order with a reference product.
 */
`timescale 1ns/1ps
`include "mma_consts.svh"

module mma_tb;

    localparam logic [31:0] SEED = 32'h559a_d283;
    localparam int RUN_LIMIT = 100000;              // Cycles for the whole sequence

    logic        CLK100MHZ = 1'b0;
    logic        reset_i;
    logic [7:0]  rx_data_i;
    logic        rx_valid_i;
    logic        tx_busy_i;
    logic [7:0]  tx_data_o;
    logic        tx_valid_o;

    logic [7:0]  got_q [$];                         // Bytes from the DUT
    logic [7:0]  exp_q [$];                         // Bytes still expected
    logic [31:0] a_words [`MMA_DEPTH];              // Full words as sent
    logic [31:0] b_words [`MMA_DEPTH];
    logic [31:0] r_words [`MMA_DEPTH];              // Expected R, row-major
    int          a_rows;
    int          a_cols;
    int          b_cols;
    int          r_rows;
    int          r_cols;
    logic [31:0] elem_state;                        // Element values
    logic [31:0] busy_state;                        // Sink back-pressure
    int          busy_hold;
    int          last_wait;                         // Cycles of the last reply wait
    int          checks = 0;
    int          errors = 0;
    logic        tests_done = 1'b0;                 // Sequence over or given up
    logic        run_done = 1'b0;
    string       test_name = "reset";

    mma_top i_mma_top (
        .CLK100MHZ(CLK100MHZ),
        .reset_i(reset_i),
        .rx_data_i(rx_data_i),
        .rx_valid_i(rx_valid_i),
        .tx_busy_i(tx_busy_i),
        .tx_data_o(tx_data_o),
        .tx_valid_o(tx_valid_o)
    );

    always #5 CLK100MHZ = ~CLK100MHZ;               // 100 MHz

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Wrapped sum over k of A[i][k] * B[k][j], operands are signed low halves
    function automatic logic [31:0] ref_element(input int i, input int j);
        logic signed [31:0] sum;
        logic signed [31:0] ea;
        logic signed [31:0] eb;
        sum = '0;
        for (int k = 0; k < a_cols; k++) begin
            ea  = {{16{a_words[i*a_cols+k][15]}}, a_words[i*a_cols+k][15:0]};
            eb  = {{16{b_words[k*b_cols+j][15]}}, b_words[k*b_cols+j][15:0]};
            sum = sum + ea * eb;                    // Low 32 bits only
        end
        return sum;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    // One strobe, then idle cycles so the controller can switch modes
    task automatic send_byte(input logic [7:0] b);
        @(posedge CLK100MHZ);
        #1;
        rx_data_i  = b;
        rx_valid_i = 1'b1;
        @(posedge CLK100MHZ);
        #1;
        rx_valid_i = 1'b0;
        repeat (2) @(posedge CLK100MHZ);
    endtask

    task automatic send_word(input logic [31:0] w);
        for (int b = 3; b >= 0; b--) begin
            send_byte(w[b*8 +: 8]);                 // Big-endian
        end
    endtask

    task automatic push_word(input logic [31:0] w);
        for (int b = 3; b >= 0; b--) begin
            exp_q.push_back(w[b*8 +: 8]);
        end
    endtask

    task automatic wait_replies(input int limit);
        last_wait = 0;
        while (exp_q.size() != 0 && last_wait < limit) begin
            @(posedge CLK100MHZ);
            last_wait++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Timeout in %s: %0d reply bytes not received within %0d cycles",
                     test_name, exp_q.size(), limit);
            tests_done = 1'b1;
            forever @(posedge CLK100MHZ);           // Held here until the report ends the run
        end
    endtask

    // No byte beyond the expected ones
    task automatic expect_quiet();
        repeat (40) @(posedge CLK100MHZ);
        check({test_name, " extra bytes"}, 32'd0, got_q.size());
    endtask

    task automatic load_matrix(input logic [7:0] cmd, input int rows, input int cols);
        logic [31:0] w;
        exp_q.push_back(`MMA_REPLY_ACK);
        send_byte(cmd);
        send_word(rows);
        send_word(cols);
        for (int e = 0; e < rows * cols; e++) begin
            elem_state = xorshift32(elem_state);
            w = elem_state;                         // Upper half must be ignored
            if (cmd == `MMA_CMD_RX_B) begin
                b_words[e] = w;
            end else begin
                a_words[e] = w;
            end
            send_word(w);
        end
        if (cmd == `MMA_CMD_RX_B) begin
            b_cols = cols;
        end else begin
            a_rows = rows;
            a_cols = cols;
        end
        wait_replies(500);
        expect_quiet();
    endtask

    task automatic run_multiply(input logic [7:0] reply);
        exp_q.push_back(reply);
        send_byte(`MMA_CMD_MULTIPLY);
        wait_replies(5000);
        expect_quiet();
    endtask

    task automatic compute_result();
        r_rows = a_rows;
        r_cols = b_cols;
        for (int i = 0; i < r_rows; i++) begin
            for (int j = 0; j < r_cols; j++) begin
                r_words[i*r_cols+j] = ref_element(i, j);
            end
        end
    endtask

    // Dimensions first, then R row-major
    task automatic read_result();
        push_word(r_rows);
        push_word(r_cols);
        for (int e = 0; e < r_rows * r_cols; e++) begin
            push_word(r_words[e]);
        end
        send_byte(`MMA_CMD_TX_R);
        wait_replies(20000);
        expect_quiet();
    endtask

    // Sink model, random busy after every byte
    always begin
        @(negedge CLK100MHZ);
        if (tx_valid_o) begin
            got_q.push_back(tx_data_o);
            busy_state = xorshift32(busy_state);
            busy_hold  = busy_state % 6;            // 0 to 5 cycles
            @(posedge CLK100MHZ);
            #1;
            if (busy_hold != 0) begin
                tx_busy_i = 1'b1;
                repeat (busy_hold) @(posedge CLK100MHZ);
                #1;
                tx_busy_i = 1'b0;
            end
        end
    end

    // Byte comparator
    always @(posedge CLK100MHZ) begin
        while (got_q.size() != 0 && exp_q.size() != 0) begin
            check(test_name, exp_q.pop_front(), got_q.pop_front());
        end
    end

    // Closing report once the sequence ends or a reply wait gives up
    initial begin
        int cycles;
        cycles = 0;
        while (!tests_done && cycles < RUN_LIMIT) begin
            @(posedge CLK100MHZ);
            cycles++;
        end
        if (!tests_done) begin
            errors++;
            $display("Run did not finish within %0d cycles", RUN_LIMIT);
        end
        run_done = 1'b1;
        $display("mma_tb: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        reset_i    = 1'b1;
        rx_data_i  = 8'h00;
        rx_valid_i = 1'b0;
        tx_busy_i  = 1'b0;
        elem_state = SEED;
        busy_state = SEED;
        repeat (3) @(posedge CLK100MHZ);
        #1;
        reset_i = 1'b0;

        // 3x4 times 4x2
        test_name = "load_3x4_4x2";
        load_matrix(`MMA_CMD_RX_A, 3, 4);
        load_matrix(`MMA_CMD_RX_B, 4, 2);
        test_name = "multiply_3x4_4x2";
        run_multiply(`MMA_REPLY_DONE);
        compute_result();
        test_name = "transmit_3x2";
        read_result();

        // Largest size, busy sink throughout
        test_name = "load_8x8";
        load_matrix(`MMA_CMD_RX_A, 8, 8);
        load_matrix(`MMA_CMD_RX_B, 8, 8);
        test_name = "multiply_8x8";
        run_multiply(`MMA_REPLY_DONE);
        compute_result();
        test_name = "transmit_8x8";
        read_result();

        // Inner dimensions 4 and 5, R keeps the 8x8 result
        test_name = "load_mismatch";
        load_matrix(`MMA_CMD_RX_A, 3, 4);
        load_matrix(`MMA_CMD_RX_B, 5, 2);
        test_name = "multiply_mismatch";
        run_multiply(`MMA_REPLY_ERR);
        test_name = "transmit_unchanged";
        read_result();

        // Element cut after two bytes
        test_name = "rx_timeout";
        exp_q.push_back(`MMA_REPLY_ERR);
        send_byte(`MMA_CMD_RX_A);
        send_word(32'd2);
        send_word(32'd2);
        send_word(32'h0000_1234);
        send_byte(8'h12);
        send_byte(8'h34);
        wait_replies(3 * `MMA_RX_TIMEOUT);
        check("rx_timeout not early", 32'd1, last_wait >= `MMA_RX_TIMEOUT - 4);
        expect_quiet();
        test_name = "load_after_timeout";
        load_matrix(`MMA_CMD_RX_B, 2, 3);

        test_name = "dim_9";
        exp_q.push_back(`MMA_REPLY_ERR);
        send_byte(`MMA_CMD_RX_A);
        send_word(32'd9);                           // Rejected at the first dimension
        wait_replies(500);
        expect_quiet();
        test_name = "dim_0";
        exp_q.push_back(`MMA_REPLY_ERR);
        send_byte(`MMA_CMD_RX_B);
        send_word(32'd3);
        send_word(32'd0);
        wait_replies(500);
        expect_quiet();

        tests_done = 1'b1;
    end

    // Run stopped by an assertion or the simulator
    final begin
        if (!run_done) begin
            $display("mma_tb: run stopped early, %0d checks, %0d errors", checks, errors);
            $display("Checks failed");
        end
    end

endmodule
